// ==== cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] word_t;     // register or data word
    typedef logic [4:0]  reg_addr_t; // cp0 register number
    typedef logic [4:0]  exc_code_t; // cause exccode
    typedef logic [7:0]  int_vec_t;  // ip / im, sw 1:0, hw 7:2

    // implemented register numbers
    localparam reg_addr_t reg_badvaddr = 5'd8;
    localparam reg_addr_t reg_count    = 5'd9;
    localparam reg_addr_t reg_compare  = 5'd11;
    localparam reg_addr_t reg_status   = 5'd12;
    localparam reg_addr_t reg_cause    = 5'd13;
    localparam reg_addr_t reg_epc      = 5'd14;
    localparam reg_addr_t reg_prid     = 5'd15;
    localparam reg_addr_t reg_config   = 5'd16;

    // reset and constant values
    localparam word_t status_reset  = 32'h0040_ff00; // bev set, all im set
    localparam word_t config_reset  = 32'h0000_8000;
    localparam word_t prid_value    = 32'h0001_8001; // fixed core id
    localparam word_t read_unmapped = 32'hffff_ffff;

    // bits software may change through mtc0
    localparam word_t status_wmask = 32'h0000_ff03; // im, exl, ie
    localparam word_t cause_wmask  = 32'h0000_0300; // ip1:ip0 only

    // single-bit field positions
    localparam int status_ie_bit  = 0;
    localparam int status_exl_bit = 1;
    localparam int cause_bd_bit   = 31;

    // exception report from the pipeline
    typedef struct packed {
        exc_code_t exc_code;
        logic      branch_delay;   // faulting instr sits in a delay slot
        word_t     epc;
        word_t     badvaddr;
        logic      badvaddr_valid; // load badvaddr as well
    } exc_info_t;

    // resolved register updates, one cycle worth
    typedef struct packed {
        logic      status_we;
        logic      cause_sw_we;
        logic      epc_we;
        logic      badvaddr_we;
        logic      config_we;
        logic      count_we;
        logic      compare_we;
        logic      exc_we;       // load exccode and bd
        exc_code_t exc_code;
        logic      branch_delay;
        logic      exl_set;
        logic      exl_clear;
        word_t     data;         // mtc0 data, or epc on exception
        word_t     badvaddr;     // exception bad address, else mtc0 data
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== cp0_write_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_write_decode
    import cp0_pkg::*;
(
    input  logic      mtc0_we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  logic      exc_we,
    input  exc_info_t exc,
    input  logic      eret,
    output reg_wr_t   wr
);

    // priority: exception, then eret, then mtc0
    always_comb begin
        wr          = '0;
        wr.data     = wdata;
        wr.badvaddr = wdata;
        if (exc_we) begin
            wr.exc_we       = 1'b1;
            wr.exc_code     = exc.exc_code;
            wr.branch_delay = exc.branch_delay;
            wr.exl_set      = 1'b1;
            wr.epc_we       = 1'b1;
            wr.data         = exc.epc;            // epc rides on the data word
            wr.badvaddr_we  = exc.badvaddr_valid; // only address faults
            wr.badvaddr     = exc.badvaddr;
        end else if (eret) begin
            wr.exl_clear = 1'b1;                  // back to user level
        end else if (mtc0_we) begin
            // one enable per address
            case (waddr)
                reg_badvaddr: wr.badvaddr_we = 1'b1;
                reg_count:    wr.count_we    = 1'b1;
                reg_compare:  wr.compare_we  = 1'b1;
                reg_status:   wr.status_we   = 1'b1;
                reg_cause:    wr.cause_sw_we = 1'b1;
                reg_epc:      wr.epc_we      = 1'b1;
                reg_config:   wr.config_we   = 1'b1;
                default: begin
                    // prid is a constant, unmapped numbers drop the write
                end
            endcase
        end
    end

    // pipeline never retires an eret in the same cycle it faults
    always_comb begin
        assert (!(exc_we && eret))
            else $error("cp0: exc_we and eret high together");
    end

endmodule

`default_nettype wire

// ==== cp0_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_timer
    import cp0_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  reg_wr_t wr,
    output word_t   count,
    output word_t   compare,
    output logic    timer_int
);

    logic hit; // count reached compare

    // compare of zero is treated as disarmed, so reset doesn't fire the timer
    assign hit = (count == compare) && (compare != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count     <= '0;
            compare   <= '0;
            timer_int <= 1'b0;
        end else begin
            count <= wr.count_we ? wr.data : count + 32'd1; // free running
            if (wr.compare_we) begin
                compare   <= wr.data;
                timer_int <= 1'b0;       // compare write acks the timer
            end else if (hit) begin
                timer_int <= 1'b1;       // sticky until acked
            end
        end
    end

    // ack must win over a coincident hit
    ap_compare_ack : assert property (
        @(posedge clk) disable iff (rst) wr.compare_we |=> !timer_int
    ) else $error("cp0: timer_int still set after compare write");

endmodule

`default_nettype wire

// ==== cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import cp0_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_wr_t   wr,
    input  logic [5:0] hw_int,
    input  word_t     count,
    input  word_t     compare,
    input  logic      timer_int,
    input  reg_addr_t raddr,
    output word_t     rdata,
    output word_t     epc_out,
    output logic      int_req,
    output logic      kernel_mode
);

    word_t    status;
    word_t    cause_q;   // sw ip, exccode, bd only, rest stays zero
    word_t    epc;
    word_t    badvaddr;
    word_t    config_q;
    word_t    cause;     // assembled view with live ip
    int_vec_t ip;        // pending interrupts
    int_vec_t im;        // status interrupt mask

    // status, masked mtc0 plus exl side effects
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status <= status_reset;
        end else begin
            if (wr.status_we)
                status <= (status & ~status_wmask) | (wr.data & status_wmask);
            if (wr.exl_set)
                status[status_exl_bit] <= 1'b1;  // enter kernel level
            if (wr.exl_clear)
                status[status_exl_bit] <= 1'b0;  // eret
        end
    end

    // cause, stored part
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_q <= '0;
        end else if (wr.exc_we) begin
            cause_q[cause_bd_bit] <= wr.branch_delay;
            cause_q[6:2]          <= wr.exc_code;
        end else if (wr.cause_sw_we) begin
            cause_q <= (cause_q & ~cause_wmask) | (wr.data & cause_wmask); // ip1:ip0
        end
    end

    // epc, badvaddr, config
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epc      <= '0;
            badvaddr <= '0;
            config_q <= config_reset;
        end else begin
            if (wr.epc_we)
                epc <= wr.data;          // exception pc or mtc0
            if (wr.badvaddr_we)
                badvaddr <= wr.badvaddr;
            if (wr.config_we)
                config_q <= wr.data;
        end
    end

    // live pending bits, timer shares hw line 5 (ip7)
    assign ip = {hw_int[5] | timer_int, hw_int[4:0], cause_q[9:8]};
    assign im = status[15:8];

    assign cause = {cause_q[31:16], ip, cause_q[7:0]};

    // ie and not exl, then any unmasked pending bit
    assign int_req = status[status_ie_bit] & ~status[status_exl_bit] & (|(ip & im));

    assign kernel_mode = status[status_exl_bit];
    assign epc_out     = epc;

    // read port, no latency
    always_comb begin
        case (raddr)
            reg_badvaddr: rdata = badvaddr;
            reg_count:    rdata = count;
            reg_compare:  rdata = compare;
            reg_status:   rdata = status;
            reg_cause:    rdata = cause;
            reg_epc:      rdata = epc;
            reg_prid:     rdata = prid_value;  // constant id
            reg_config:   rdata = config_q;
            default:      rdata = read_unmapped;
        endcase
    end

    // read-only status bits hold their reset pattern through every write path
    ap_status_ro : assert property (
        @(posedge clk) disable iff (rst)
            (status & ~status_wmask) == (status_reset & ~status_wmask)
    ) else $error("cp0: read-only status bits changed");

endmodule

`default_nettype wire

// ==== cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top
    import cp0_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mtc0_we,
    input  reg_addr_t  waddr,
    input  word_t      wdata,
    input  logic       exc_we,
    input  exc_info_t  exc,
    input  logic       eret,
    input  reg_addr_t  raddr,
    input  logic [5:0] hw_int,
    output word_t      rdata,
    output word_t      epc_out,
    output logic       int_req,
    output logic       kernel_mode
);

    reg_wr_t wr;        // resolved updates
    word_t   count;
    word_t   compare;
    logic    timer_int; // into ip7

    cp0_write_decode i_write_decode (
        .mtc0_we (mtc0_we),
        .waddr   (waddr),
        .wdata   (wdata),
        .exc_we  (exc_we),
        .exc     (exc),
        .eret    (eret),
        .wr      (wr)
    );

    cp0_timer i_timer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

    cp0_regs i_regs (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .hw_int      (hw_int),
        .count       (count),
        .compare     (compare),
        .timer_int   (timer_int),
        .raddr       (raddr),
        .rdata       (rdata),
        .epc_out     (epc_out),
        .int_req     (int_req),
        .kernel_mode (kernel_mode)
    );

endmodule

`default_nettype wire

// ==== tb_cp0.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cp0
    import cp0_pkg::*;
();

    localparam int clk_period = 4;
    localparam int reset_cycles = 16;
    // rough cycle counts per test summed for the watchdog
    localparam int cycle_budget = reset_cycles + 34 + 32 * 3 + 8 * 9 + 32 * 4 + 4 * 24;

    logic       clk;
    logic       rst;
    logic       mtc0_we;
    reg_addr_t  waddr;
    word_t      wdata;
    logic       exc_we;
    exc_info_t  exc;
    logic       eret;
    reg_addr_t  raddr;
    logic [5:0] hw_int;
    word_t      rdata;
    word_t      epc_out;
    logic       int_req;
    logic       kernel_mode;

    // shadow registers
    word_t m_status, m_cause, m_epc, m_badvaddr, m_config, m_count, m_compare;
    logic  m_timer;

    word_t lfsr = 32'h6b84;
    int    n_checks = 0;
    int    n_errors = 0;
    int    errs_before;
    word_t r_a, r_b, r_c, r_d, r_e, r_f;
    int    off;
    logic  seen;

    cp0_top i_cp0_top (
        .clk(clk), .rst(rst), .mtc0_we(mtc0_we), .waddr(waddr), .wdata(wdata),
        .exc_we(exc_we), .exc(exc), .eret(eret), .raddr(raddr), .hw_int(hw_int),
        .rdata(rdata), .epc_out(epc_out), .int_req(int_req), .kernel_mode(kernel_mode)
    );

    always #(clk_period / 2) clk = ~clk;

    // model mirrors every issued write at the same edge as the dut
    always @(posedge clk or posedge rst) begin
        logic hit;
        logic cmp_wr;
        if (rst) begin
            m_status  = status_reset;
            m_cause   = '0;
            m_epc     = '0;
            m_badvaddr = '0;
            m_config  = config_reset;
            m_count   = '0;
            m_compare = '0;
            m_timer   = 1'b0;
        end else begin
            hit    = (m_count == m_compare) && (m_compare != '0); // zero compare is disarmed
            cmp_wr = 1'b0;
            m_count = m_count + 32'd1;
            if (exc_we) begin
                m_status[status_exl_bit] = 1'b1;
                m_epc = exc.epc;
                m_cause[cause_bd_bit] = exc.branch_delay;
                m_cause[6:2] = exc.exc_code;
                if (exc.badvaddr_valid)
                    m_badvaddr = exc.badvaddr;
            end else if (eret) begin
                m_status[status_exl_bit] = 1'b0;
            end else if (mtc0_we) begin
                case (waddr)
                    reg_status:   m_status = (m_status & ~status_wmask) | (wdata & status_wmask);
                    reg_cause:    m_cause = (m_cause & ~cause_wmask) | (wdata & cause_wmask);
                    reg_epc:      m_epc = wdata;
                    reg_badvaddr: m_badvaddr = wdata;
                    reg_config:   m_config = wdata;
                    reg_count:    m_count = wdata;
                    reg_compare: begin
                        m_compare = wdata;
                        cmp_wr = 1'b1;
                    end
                    default: ;
                endcase
            end
            if (cmp_wr)
                m_timer = 1'b0;   // ack
            else if (hit)
                m_timer = 1'b1;
        end
    end

    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int nbits, output word_t val);
        val = '0;
        for (int k = 0; k < nbits; k++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t expected_rdata(input reg_addr_t a, input logic [5:0] hw);
        word_t cause_v;
        cause_v = m_cause;
        cause_v[15:10] = {hw[5] | m_timer, hw[4:0]}; // live ip7..ip2
        case (a)
            reg_badvaddr: return m_badvaddr;
            reg_count:    return m_count;
            reg_compare:  return m_compare;
            reg_status:   return m_status;
            reg_cause:    return cause_v;
            reg_epc:      return m_epc;
            reg_prid:     return prid_value;
            reg_config:   return m_config;
            default:      return read_unmapped;
        endcase
    endfunction

    function automatic logic compute_int_req(input logic [5:0] hw);
        int_vec_t ip;
        ip = {hw[5] | m_timer, hw[4:0], m_cause[9:8]};
        return m_status[status_ie_bit] & ~m_status[status_exl_bit] & (|(ip & m_status[15:8]));
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: finished, %0d errors", name, n_errors - errs_before);
        errs_before = n_errors;
    endtask

    // starts and ends on a falling edge
    task automatic write_reg(input reg_addr_t a, input word_t d);
        mtc0_we = 1'b1;
        waddr   = a;
        wdata   = d;
        @(negedge clk);
        mtc0_we = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t a);
        raddr = a;
        #1;
        if (a != reg_count)       // count only checked in the timer test
            check($sformatf("rdata[%0d]", a), rdata, expected_rdata(a, hw_int));
        check("int_req", 32'(int_req), 32'(compute_int_req(hw_int)));
        check("kernel_mode", 32'(kernel_mode), 32'(m_status[status_exl_bit]));
        @(negedge clk);
    endtask

    initial begin
        #(cycle_budget * 2 * clk_period);
        $display("watchdog expired after %0d cycles, run did not finish", cycle_budget * 2);
        $display("test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mtc0_we = 1'b0;
        waddr = '0;
        wdata = '0;
        exc_we = 1'b0;
        exc = '0;
        eret = 1'b0;
        raddr = '0;
        hw_int = '0;
        errs_before = 0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // reset values over the whole address space
        check("int_req", 32'(int_req), 32'd0);
        check("kernel_mode", 32'(kernel_mode), 32'd0);
        for (int a = 0; a < 32; a++)
            read_check(reg_addr_t'(a));
        report_test("reset values");

        // mtc0 to every number including prid and unmapped ones
        for (int a = 0; a < 32; a++) begin
            draw(32, r_a);
            write_reg(reg_addr_t'(a), r_a);
            read_check(reg_addr_t'(a));
        end
        raddr = reg_status;
        #1;
        check("status read-only bits", rdata & ~status_wmask, status_reset & ~status_wmask);
        @(negedge clk);
        report_test("general writes");

        // exception with a competing mtc0 and a following eret
        for (int i = 0; i < 8; i++) begin
            draw(5, r_a);
            draw(1, r_b);
            draw(32, r_c);
            draw(32, r_d);
            draw(5, r_e);
            draw(32, r_f);
            exc.exc_code       = r_a[4:0];
            exc.branch_delay   = r_b[0];
            exc.epc            = r_c;
            exc.badvaddr       = r_d;
            exc.badvaddr_valid = i[0];   // alternate address faults
            exc_we  = 1'b1;
            mtc0_we = 1'b1;
            waddr   = r_e[4:0];
            wdata   = r_f;
            @(negedge clk);
            exc_we  = 1'b0;
            mtc0_we = 1'b0;
            read_check(reg_epc);
            read_check(reg_cause);
            read_check(reg_badvaddr);
            read_check(reg_status);
            read_check(reg_config);
            read_check(reg_compare);
            check("kernel_mode", 32'(kernel_mode), 32'd1);
            check("epc_out", epc_out, m_epc);
            eret = 1'b1;
            @(negedge clk);
            eret = 1'b0;
            #1;
            check("kernel_mode", 32'(kernel_mode), 32'd0);
            @(negedge clk);
        end
        report_test("exception entry and return");

        // random masks, sw bits and live hw lines
        for (int i = 0; i < 32; i++) begin
            draw(6, r_a);
            draw(32, r_b);
            draw(32, r_c);
            write_reg(reg_status, r_b);
            write_reg(reg_cause, r_c);
            hw_int = r_a[5:0];       // changes with no clock edge
            read_check(reg_cause);
        end
        report_test("interrupt masking");

        // count / compare timer
        hw_int = '0;
        for (int i = 0; i < 4; i++) begin
            draw(31, r_a);
            draw(3, r_b);
            off = int'(r_b[2:0]) + 3;
            write_reg(reg_count, r_a);
            write_reg(reg_compare, r_a + 32'(off));
            raddr = reg_count;
            #1;
            check("count", rdata, r_a + 32'd1);
            @(negedge clk);
            seen = 1'b0;
            for (int k = 0; k < off + 2 && !seen; k++) begin
                raddr = reg_cause;
                #1;
                seen = rdata[15];
                if (seen)
                    check("cause", rdata, expected_rdata(reg_cause, hw_int));
                @(negedge clk);
            end
            if (!seen) begin
                n_errors++;
                $display("timer interrupt did not reach cause bit 15 within %0d cycles", off + 2);
            end
            write_reg(reg_compare, r_a + 32'h0010_0000); // far ahead so the timer is acked
            raddr = reg_cause;
            #1;
            check("cause timer bit", 32'(rdata[15]), 32'd0);
            @(negedge clk);
        end
        report_test("timer");

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
cp0_pkg.sv
cp0_write_decode.sv
cp0_timer.sv
cp0_regs.sv
cp0_top.sv
tb_cp0.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = tb_cp0
FILELIST = sources.f
BUILD    = obj_dir

SOURCES  = $(shell cat $(FILELIST))
BIN      = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)
